// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

	////////////////////////////////////////
	// System constants
	////////////////////////////////////////

	// Transmit channels sharing one serial line
	localparam int NUM_LANES = 2;

	// Entries per channel FIFO and initial credits per host
	localparam int FIFO_DEPTH = 4;

	// Default clocks per half bit
	localparam int HALF_BIT_CLKS = 4;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [7:0] byte_t;

	// Channel index
	typedef logic [0:0] lane_id_t;

	typedef logic [1:0] fifo_ptr_t;

	// One bit wider than the pointer so a full FIFO can be told apart
	typedef logic [2:0] fifo_cnt_t;

	// Serial frame phases
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

`default_nettype wire

// File: tx_lane_if.sv
`default_nettype none

// One transmit channel as seen by the arbiter
interface tx_lane_if;

	// FIFO holds at least one byte
	logic               req;
	// Head byte of the FIFO
	uart_pkg::byte_t    data;
	// Single-cycle pop strobe from the arbiter
	logic               grant;
	// Source tag, tied per instance at the top level
	uart_pkg::lane_id_t lane;

	modport channel (
		output req,
		output data,
		input  grant
	);

	modport arbiter (
		input  req,
		input  data,
		input  lane,
		output grant
	);

endinterface

`default_nettype wire

// File: tx_channel.sv
`default_nettype none

module tx_channel (
	input  logic            clk,
	input  logic            rstn,
	input  logic            push,
	input  uart_pkg::byte_t push_data,
	output logic            credit,
	tx_lane_if.channel      lane
);

	uart_pkg::byte_t     mem [uart_pkg::FIFO_DEPTH];
	uart_pkg::fifo_ptr_t wr_ptr;
	uart_pkg::fifo_ptr_t rd_ptr;
	uart_pkg::fifo_cnt_t count;
	logic                full;
	logic                wr_en;
	logic                rd_en;

	// Circular pointer advance
	function automatic uart_pkg::fifo_ptr_t next_ptr(input uart_pkg::fifo_ptr_t ptr);
		if (ptr == uart_pkg::fifo_ptr_t'(uart_pkg::FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + uart_pkg::fifo_ptr_t'(1);
	endfunction

	assign full = (count == uart_pkg::fifo_cnt_t'(uart_pkg::FIFO_DEPTH));

	// A push with no free entry is dropped
	assign wr_en = push && !full;
	assign rd_en = lane.grant && lane.req;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + uart_pkg::fifo_cnt_t'(1);
				2'b01: count <= count - uart_pkg::fifo_cnt_t'(1);
				default: count <= count;
			endcase
		end
	end

	// One credit back per byte handed over, a cycle after the grant
	always_ff @(posedge clk) begin
		if (!rstn) begin
			credit <= 1'b0;
		end else begin
			credit <= rd_en;
		end
	end

	// Head of queue toward the arbiter
	assign lane.req  = (count != '0);
	assign lane.data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: tx_arbiter.sv
`default_nettype none

module tx_arbiter (
	input  logic            clk,
	input  logic            rstn,
	tx_lane_if.arbiter      lanes [0:uart_pkg::NUM_LANES-1],
	input  logic            tx_busy,
	output logic            tx_start,
	output uart_pkg::byte_t tx_data
);

	localparam int N = uart_pkg::NUM_LANES;

	logic [N-1:0]       req_vec;
	uart_pkg::byte_t    data_arr [N];
	uart_pkg::lane_id_t tag_arr [N];
	logic [N-1:0]       grant_q;
	uart_pkg::lane_id_t last_q;
	uart_pkg::lane_id_t pick;
	logic               found;
	logic               decide;

	// Flatten the interface array
	for (genvar g = 0; g < N; g++) begin : g_lane
		assign req_vec[g]     = lanes[g].req;
		assign data_arr[g]    = lanes[g].data;
		assign tag_arr[g]     = lanes[g].lane;
		assign lanes[g].grant = grant_q[g];
	end

	////////////////////////////////////////
	// Round-robin selection
	////////////////////////////////////////

	// Search starts just past the last lane served
	always_comb begin : rr_pick
		int idx;
		found = 1'b0;
		pick  = last_q;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(last_q) + k) % N;
			if (!found && req_vec[idx]) begin
				found = 1'b1;
				pick  = uart_pkg::lane_id_t'(idx);
			end
		end
	end

	// Skip the strobe cycle itself since busy is not yet visible
	assign decide = found && !tx_busy && !tx_start;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			grant_q  <= '0;
			tx_start <= 1'b0;
			last_q   <= uart_pkg::lane_id_t'(N - 1);
		end else begin
			grant_q  <= '0;
			tx_start <= decide;
			if (decide) begin
				grant_q[pick] <= 1'b1;
				last_q        <= tag_arr[pick];
			end
		end
	end

	// Byte travels with the start strobe
	always_ff @(posedge clk) begin
		if (decide) begin
			tx_data <= data_arr[pick];
		end
	end

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx #(
	parameter int HALF_BIT_CLKS = uart_pkg::HALF_BIT_CLKS
) (
	input  logic            clk,
	input  logic            rstn,
	input  logic            tx_start,
	input  uart_pkg::byte_t tx_data,
	output logic            tx_busy,
	output logic            txd
);

	// Every bit including start and stop has this length
	localparam int BIT_CLKS = 2 * HALF_BIT_CLKS;
	localparam int CNT_W = $clog2(BIT_CLKS);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);

	uart_pkg::tx_state_t state;
	logic [CNT_W-1:0]    clk_cnt;
	logic [2:0]          bit_idx;
	uart_pkg::byte_t     shreg;
	logic                bit_end;

	assign bit_end = (clk_cnt == BIT_LAST);

	////////////////////////////////////////
	// Frame sequencer
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state   <= uart_pkg::TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx_busy <= 1'b0;
			txd     <= 1'b1;
		end else begin
			if (state == uart_pkg::TX_IDLE) begin
				clk_cnt <= '0;
			end else if (bit_end) begin
				clk_cnt <= '0;
			end else begin
				clk_cnt <= clk_cnt + CNT_W'(1);
			end

			case (state)
				uart_pkg::TX_IDLE: begin
					if (tx_start) begin
						state   <= uart_pkg::TX_START;
						tx_busy <= 1'b1;
						txd     <= 1'b0;
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						state   <= uart_pkg::TX_DATA;
						bit_idx <= '0;
						txd     <= shreg[0];
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::TX_STOP;
							txd   <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 3'd1;
							txd     <= shreg[0];
						end
					end
				end
				uart_pkg::TX_STOP: begin
					// Line already idles high
					if (bit_end) begin
						state   <= uart_pkg::TX_IDLE;
						tx_busy <= 1'b0;
					end
				end
				default: state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// LSB first, ones fill from the top
	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_IDLE && tx_start) begin
			shreg <= tx_data;
		end else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
			shreg <= {1'b1, shreg[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: uart_tx_top.sv
`default_nettype none

module uart_tx_top (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic [uart_pkg::NUM_LANES-1:0] push,
	input  uart_pkg::byte_t                push_data0,
	input  uart_pkg::byte_t                push_data1,
	output logic [uart_pkg::NUM_LANES-1:0] credit,
	output logic                           txd,
	output logic                           tx_busy
);

	logic            tx_start;
	uart_pkg::byte_t tx_data;

	tx_lane_if lane_if [0:uart_pkg::NUM_LANES-1] ();

	// Each lane carries its own index as source tag
	for (genvar i = 0; i < uart_pkg::NUM_LANES; i++) begin : g_tag
		assign lane_if[i].lane = uart_pkg::lane_id_t'(i);
	end

	////////////////////////////////////////
	// Host channels
	////////////////////////////////////////

	tx_channel chan0_inst (
		.clk       (clk),
		.rstn      (rstn),
		.push      (push[0]),
		.push_data (push_data0),
		.credit    (credit[0]),
		.lane      (lane_if[0])
	);

	tx_channel chan1_inst (
		.clk       (clk),
		.rstn      (rstn),
		.push      (push[1]),
		.push_data (push_data1),
		.credit    (credit[1]),
		.lane      (lane_if[1])
	);

	////////////////////////////////////////
	// Shared serial path
	////////////////////////////////////////

	tx_arbiter arbiter_inst (
		.clk      (clk),
		.rstn     (rstn),
		.lanes    (lane_if),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data)
	);

	uart_tx #(
		.HALF_BIT_CLKS (uart_pkg::HALF_BIT_CLKS)
	) uart_tx_inst (
		.clk      (clk),
		.rstn     (rstn),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.txd      (txd)
	);

endmodule

`default_nettype wire

// File: tb_uart_monitor.sv
`default_nettype none

module tb_uart_monitor (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic [uart_pkg::NUM_LANES-1:0] push,
	input  uart_pkg::byte_t                push_data0,
	input  uart_pkg::byte_t                push_data1,
	input  logic [uart_pkg::NUM_LANES-1:0] credit,
	input  logic                           txd,
	input  logic                           tx_busy,
	input  logic [127:0]                   test_name,
	input  logic                           alt_check,
	input  logic                           done,
	output int                             frames,
	output int                             errors
);

	localparam int BIT_CLKS = 2 * uart_pkg::HALF_BIT_CLKS;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	localparam int MID = BIT_CLKS / 2;

	uart_pkg::byte_t exp_q0 [$];
	uart_pkg::byte_t exp_q1 [$];
	logic [127:0]    name_q0 [$];
	logic [127:0]    name_q1 [$];
	int              pushed [uart_pkg::NUM_LANES];
	int              credited [uart_pkg::NUM_LANES];
	int              err_cnt;
	int              frame_cnt;
	int              pos;
	bit              in_frame;
	bit              have_prev;
	bit              prev_ch;
	bit              final_done;
	uart_pkg::byte_t rx_byte;

	// Expected bytes in push order, one queue per channel
	always @(posedge clk) begin
		if (rstn) begin
			if (push[0]) begin
				exp_q0.push_back(push_data0);
				name_q0.push_back(test_name);
				pushed[0]++;
			end
			if (push[1]) begin
				exp_q1.push_back(push_data1);
				name_q1.push_back(test_name);
				pushed[1]++;
			end
		end
	end

	task automatic finish_frame();
		bit              ch;
		uart_pkg::byte_t exp_byte;
		logic [127:0]    name;
		// Bit 7 tells the source channel
		ch = rx_byte[7];
		frame_cnt++;
		if (alt_check) begin
			if (have_prev && ch == prev_ch) begin
				err_cnt++;
				$display("[ERROR] %0s: expected channel %0d, actual channel %0d",
					test_name, !prev_ch, ch);
			end
			have_prev = 1'b1;
			prev_ch   = ch;
		end
		if ((ch ? exp_q1.size() : exp_q0.size()) == 0) begin
			err_cnt++;
			$display("Byte 0x%02h arrived with nothing pending on channel %0d", rx_byte, ch);
		end else begin
			if (ch) begin
				exp_byte = exp_q1.pop_front();
				name     = name_q1.pop_front();
			end else begin
				exp_byte = exp_q0.pop_front();
				name     = name_q0.pop_front();
			end
			if (exp_byte != rx_byte) begin
				err_cnt++;
				$display("[ERROR] %0s: expected 0x%02h, actual 0x%02h", name, exp_byte, rx_byte);
			end
		end
	endtask

	////////////////////////////////////////
	// Line decoding and credit checks
	////////////////////////////////////////

	always @(negedge clk) begin
		if (rstn) begin
			for (int ch = 0; ch < uart_pkg::NUM_LANES; ch++) begin
				if (credit[ch]) begin
					credited[ch]++;
				end
				if (credited[ch] > pushed[ch]) begin
					err_cnt++;
					$display("Credit pulse on channel %0d with no byte outstanding", ch);
				end
			end
			// Quiet line until the first push
			if (pushed[0] + pushed[1] == 0
				&& (txd !== 1'b1 || tx_busy !== 1'b0 || credit !== '0)) begin
				err_cnt++;
				$display("Line not idle after reset: txd %b tx_busy %b credit %b",
					txd, tx_busy, credit);
			end
			if (!alt_check) begin
				have_prev = 1'b0;
			end
			if (!in_frame) begin
				if (txd === 1'b0) begin
					in_frame = 1'b1;
					pos      = 0;
					rx_byte  = '0;
					if (tx_busy !== 1'b1) begin
						err_cnt++;
						$display("Start bit seen while tx_busy is low");
					end
				end
			end else begin
				pos++;
				if (pos == MID && txd !== 1'b0) begin
					err_cnt++;
					$display("Start bit did not stay low for half a bit");
				end
				// Middle of each data bit, LSB first
				for (int k = 0; k < 8; k++) begin
					if (pos == BIT_CLKS * (k + 1) + MID) begin
						rx_byte[k] = txd;
					end
				end
				if (pos == 9 * BIT_CLKS + MID && txd !== 1'b1) begin
					err_cnt++;
					$display("Stop bit is not high");
				end
				if (pos == FRAME_CLKS - 1 && tx_busy !== 1'b1) begin
					err_cnt++;
					$display("tx_busy dropped before the end of the stop bit");
				end
				if (pos == FRAME_CLKS) begin
					if (tx_busy !== 1'b0) begin
						err_cnt++;
						$display("tx_busy still high after the stop bit");
					end
					finish_frame();
					in_frame = 1'b0;
				end
			end
			if (done && !final_done) begin
				final_done = 1'b1;
				if (exp_q0.size() + exp_q1.size() != 0) begin
					err_cnt++;
					$display("%0d pushed bytes never appeared on the line",
						exp_q0.size() + exp_q1.size());
				end
				for (int ch = 0; ch < uart_pkg::NUM_LANES; ch++) begin
					if (pushed[ch] != credited[ch]) begin
						err_cnt++;
						$display("Channel %0d took %0d pushes but returned %0d credits",
							ch, pushed[ch], credited[ch]);
					end
				end
			end
		end
		frames <= frame_cnt;
		errors <= err_cnt;
	end

endmodule

`default_nettype wire

// File: tb_uart_tx_top.sv
`default_nettype none

module tb_uart_tx_top;

	localparam int NUM_ENTRIES = 24;
	localparam int FRAME_CLKS = 20 * uart_pkg::HALF_BIT_CLKS;
	localparam int QUIET_CLKS = 20;
	localparam logic [127:0] ALT_NAME = "alternate";

	logic                           clk;
	logic                           rstn;
	logic [uart_pkg::NUM_LANES-1:0] push;
	uart_pkg::byte_t                push_data0;
	uart_pkg::byte_t                push_data1;
	logic [uart_pkg::NUM_LANES-1:0] credit;
	logic                           txd;
	logic                           tx_busy;
	logic [127:0]                   cur_name;
	logic                           alt_check;
	logic                           done;
	int                             frames;
	int                             errors;

	// Stimulus table
	logic [127:0]       tbl_name [NUM_ENTRIES];
	uart_pkg::lane_id_t tbl_chan [NUM_ENTRIES];
	uart_pkg::byte_t    tbl_data [NUM_ENTRIES];
	int                 tbl_gap [NUM_ENTRIES];

	int pushes_made [uart_pkg::NUM_LANES];
	int credits_back [uart_pkg::NUM_LANES] = '{0, 0};
	int pushes_total;
	int cycle_count = 0;
	int cycle_limit;
	int seed;

	uart_tx_top uart_tx_top_inst (
		.clk        (clk),
		.rstn       (rstn),
		.push       (push),
		.push_data0 (push_data0),
		.push_data1 (push_data1),
		.credit     (credit),
		.txd        (txd),
		.tx_busy    (tx_busy)
	);

	tb_uart_monitor monitor_inst (
		.clk        (clk),
		.rstn       (rstn),
		.push       (push),
		.push_data0 (push_data0),
		.push_data1 (push_data1),
		.credit     (credit),
		.txd        (txd),
		.tx_busy    (tx_busy),
		.test_name  (cur_name),
		.alt_check  (alt_check),
		.done       (done),
		.frames     (frames),
		.errors     (errors)
	);

	always #20 clk = ~clk;

	// Credits returned by the DUT
	always @(negedge clk) begin
		if (rstn) begin
			for (int ch = 0; ch < uart_pkg::NUM_LANES; ch++) begin
				if (credit[ch]) begin
					credits_back[ch] <= credits_back[ch] + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: no result after %0d clock cycles", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic int credits_free(input int ch);
		return uart_pkg::FIFO_DEPTH - (pushes_made[ch] - credits_back[ch]);
	endfunction

	task automatic set_entry(input int idx, input logic [127:0] name, input int ch,
		input uart_pkg::byte_t data, input int gap);
		tbl_name[idx] = name;
		tbl_chan[idx] = uart_pkg::lane_id_t'(ch);
		tbl_data[idx] = data;
		tbl_gap[idx]  = gap;
	endtask

	////////////////////////////////////////
	// Table contents
	////////////////////////////////////////

	task automatic load_table();
		logic [31:0] r;
		set_entry(0, "single_ch0", 0, 8'h35, 0);
		set_entry(1, "single_ch1", 1, 8'hca, 0);
		// More bytes than credits, so the host must stall
		for (int k = 0; k < 6; k++) begin
			set_entry(2 + k, "order_ch0", 0, 8'(8'h11 * (k + 1)), 0);
		end
		// Both FIFOs filled in the same cycles
		for (int k = 0; k < 4; k++) begin
			set_entry(8 + 2 * k, ALT_NAME, 0, 8'(8'h40 + k), 0);
			set_entry(9 + 2 * k, ALT_NAME, 1, 8'(8'hc0 + k), 0);
		end
		for (int k = 16; k < NUM_ENTRIES; k++) begin
			r = $random(seed);
			set_entry(k, "random_gap", int'(r[0]), {r[0], r[7:1]}, int'(r[10:8]));
		end
	endtask

	task automatic drive_entry(input int idx);
		cur_name = tbl_name[idx];
		if (tbl_chan[idx] == 1'b0) begin
			push[0]    = 1'b1;
			push_data0 = tbl_data[idx];
		end else begin
			push[1]    = 1'b1;
			push_data1 = tbl_data[idx];
		end
		pushes_made[tbl_chan[idx]]++;
		pushes_total++;
	endtask

	task automatic push_bytes(input int first, input logic pair);
		// A host without credit stalls
		while (credits_free(tbl_chan[first]) == 0
			|| (pair && credits_free(tbl_chan[first + 1]) == 0)) begin
			@(negedge clk);
		end
		drive_entry(first);
		if (pair) begin
			drive_entry(first + 1);
		end
		@(negedge clk);
		push = '0;
	endtask

	task automatic wait_drained();
		while (frames != pushes_total || tx_busy
			|| credits_free(0) != uart_pkg::FIFO_DEPTH
			|| credits_free(1) != uart_pkg::FIFO_DEPTH) begin
			@(negedge clk);
		end
	endtask

	initial begin
		int   i;
		int   gap_sum;
		logic pair;
		clk          = 1'b0;
		rstn         = 1'b0;
		push         = '0;
		push_data0   = '0;
		push_data1   = '0;
		cur_name     = "reset";
		alt_check    = 1'b0;
		done         = 1'b0;
		pushes_made  = '{0, 0};
		pushes_total = 0;
		seed         = 32'h3cc30da2;
		load_table();
		gap_sum = 0;
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			gap_sum += tbl_gap[k];
		end
		cycle_limit = NUM_ENTRIES * FRAME_CLKS + gap_sum + 400;

		repeat (16) @(negedge clk);
		rstn = 1'b1;
		// Idle line window, checked by the monitor
		cur_name = "after_reset";
		repeat (QUIET_CLKS) @(negedge clk);

		i = 0;
		while (i < NUM_ENTRIES) begin
			// Each test starts from an idle DUT
			if (i == 0 || tbl_name[i] != tbl_name[i - 1]) begin
				wait_drained();
				alt_check = (tbl_name[i] == ALT_NAME);
			end
			pair = tbl_gap[i] == 0 && i + 1 < NUM_ENTRIES && tbl_name[i + 1] == tbl_name[i]
				&& tbl_chan[i + 1] != tbl_chan[i];
			push_bytes(i, pair);
			repeat (tbl_gap[i + int'(pair)]) @(negedge clk);
			i += pair ? 2 : 1;
		end
		wait_drained();
		alt_check = 1'b0;
		done      = 1'b1;
		repeat (3) @(negedge clk);

		$display("Frames received %0d of %0d, errors %0d", frames, pushes_total, errors);
		if (errors == 0 && frames == pushes_total) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
uart_pkg.sv
tx_lane_if.sv
tx_channel.sv
tx_arbiter.sv
uart_tx.sv
uart_tx_top.sv
tb_uart_monitor.sv
tb_uart_tx_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_uart_tx_top -f list.f

out=$(./obj_dir/Vtb_uart_tx_top)
echo "$out"

if echo "$out" | grep -qx 'TESTBENCH PASSED'; then
	exit 0
else
	exit 1
fi
